// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_stream_top
FLIST     ?= vlog.f
BUILD_DIR ?= build
SIM_FLAGS ?=
VFLAGS    ?= --binary --timing --assert -j 0

SRCS    := $(shell grep -v '^+' $(FLIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f $(FLIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN) $(SIM_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(BUILD_DIR)

// ==== design/async_fifo.sv ====
`timescale 1ns/1ps

module async_fifo #(
  parameter int DATA_W       = stream_pkg::PAYLOAD_W,
  parameter int FIFO_DEPTH   = stream_pkg::DEF_FIFO_DEPTH,
  parameter int AFULL_LEVEL  = stream_pkg::DEF_AFULL,
  parameter int AEMPTY_LEVEL = stream_pkg::DEF_AEMPTY
) (
  input  logic              wr_clk,
  input  logic              wr_rst_n,
  input  logic              wr_valid,
  input  logic [DATA_W-1:0] wr_data,
  output logic              wr_ready,
  output logic              full,
  output logic              afull,
  input  logic              rd_clk,
  input  logic              rd_rst_n,
  input  logic              rd_ready,
  output logic              rd_valid,
  output logic [DATA_W-1:0] rd_data,
  output logic              empty,
  output logic              aempty
);

  localparam int ADDR_W = $clog2(FIFO_DEPTH);
  localparam int PTR_W  = ADDR_W + 1;  // Extra bit tells a full FIFO from an empty one.

  // Inverting the top two Gray bits gives the pointer one lap ahead.
  localparam logic [PTR_W-1:0] FULL_MASK = PTR_W'(3) << (PTR_W - 2);

  logic [PTR_W-1:0] wr_bin;
  logic [PTR_W-1:0] wr_bin_nxt;
  logic [PTR_W-1:0] wr_gray;
  logic [PTR_W-1:0] wr_gray_nxt;
  logic [PTR_W-1:0] rd_gray_wsync;
  logic [PTR_W-1:0] rd_bin_wsync;
  logic [PTR_W-1:0] wr_level;
  logic             wr_fire;

  logic [PTR_W-1:0] rd_bin;
  logic [PTR_W-1:0] rd_bin_nxt;
  logic [PTR_W-1:0] rd_gray;
  logic [PTR_W-1:0] rd_gray_nxt;
  logic [PTR_W-1:0] wr_gray_rsync;
  logic [PTR_W-1:0] wr_bin_rsync;
  logic [PTR_W-1:0] rd_level;
  logic             rd_fire;

  dual_port_ram #(
    .DATA_W (DATA_W),
    .ADDR_W (ADDR_W)
  ) u_ram (
    .wr_clk  (wr_clk),
    .wr_en   (wr_fire),
    .wr_addr (wr_bin[ADDR_W-1:0]),
    .wr_data (wr_data),
    .rd_addr (rd_bin[ADDR_W-1:0]),
    .rd_data (rd_data)
  );

  gray_sync #(.PTR_W(PTR_W)) u_rd2wr (
    .dst_clk   (wr_clk),
    .dst_rst_n (wr_rst_n),
    .gray_in   (rd_gray),
    .gray_out  (rd_gray_wsync),
    .bin_out   (rd_bin_wsync)
  );

  gray_sync #(.PTR_W(PTR_W)) u_wr2rd (
    .dst_clk   (rd_clk),
    .dst_rst_n (rd_rst_n),
    .gray_in   (wr_gray),
    .gray_out  (wr_gray_rsync),
    .bin_out   (wr_bin_rsync)
  );

  assign wr_ready    = !full;
  assign wr_fire     = wr_valid && !full;
  assign wr_bin_nxt  = wr_bin + PTR_W'(wr_fire);
  assign wr_gray_nxt = (wr_bin_nxt >> 1) ^ wr_bin_nxt;
  assign wr_level    = wr_bin_nxt - rd_bin_wsync;  // Pessimistic, the read pointer lags.

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin  <= '0;
      wr_gray <= '0;
      full    <= 1'b0;
      afull   <= 1'b0;
    end else begin
      wr_bin  <= wr_bin_nxt;
      wr_gray <= wr_gray_nxt;
      full    <= wr_gray_nxt == (rd_gray_wsync ^ FULL_MASK);
      afull   <= wr_level >= PTR_W'(AFULL_LEVEL);
    end
  end

  assign rd_valid    = !empty;
  assign rd_fire     = rd_ready && !empty;
  assign rd_bin_nxt  = rd_bin + PTR_W'(rd_fire);
  assign rd_gray_nxt = (rd_bin_nxt >> 1) ^ rd_bin_nxt;
  assign rd_level    = wr_bin_rsync - rd_bin_nxt;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin  <= '0;
      rd_gray <= '0;
      empty   <= 1'b1;
      aempty  <= 1'b1;
    end else begin
      rd_bin  <= rd_bin_nxt;
      rd_gray <= rd_gray_nxt;
      empty   <= rd_gray_nxt == wr_gray_rsync;
      aempty  <= rd_level <= PTR_W'(AEMPTY_LEVEL);
    end
  end

  a_depth_pow2: assert property (
    @(posedge wr_clk) FIFO_DEPTH >= 2 && (FIFO_DEPTH & (FIFO_DEPTH - 1)) == 0
  );

  // The registered full flag must still leave room after the read pointer crossed over.
  a_no_overflow: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
    wr_valid && wr_ready |-> wr_level <= PTR_W'(FIFO_DEPTH)
  );

  // A read is only allowed once the written entry has reached the read domain.
  a_no_underflow: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    rd_valid && rd_ready |-> rd_level <= PTR_W'(FIFO_DEPTH)
  );

endmodule

// ==== design/dual_port_ram.sv ====
`timescale 1ns/1ps

module dual_port_ram #(
  parameter int DATA_W = 9,
  parameter int ADDR_W = 4
) (
  input  logic              wr_clk,
  input  logic              wr_en,
  input  logic [ADDR_W-1:0] wr_addr,
  input  logic [DATA_W-1:0] wr_data,
  input  logic [ADDR_W-1:0] rd_addr,
  output logic [DATA_W-1:0] rd_data
);

  localparam int DEPTH = 1 << ADDR_W;

  logic [DATA_W-1:0] mem [DEPTH];

  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Asynchronous read. The entry at the read pointer is always on rd_data.
  assign rd_data = mem[rd_addr];

endmodule

// ==== design/frame_summer.sv ====
`timescale 1ns/1ps

module frame_summer (
  input  logic                             rd_clk,
  input  logic                             rd_rst_n,
  input  logic                             ff_valid,
  input  logic [stream_pkg::PAYLOAD_W-1:0] ff_data,
  output logic                             ff_ready,
  output logic                             out_valid,
  output logic [stream_pkg::BYTE_W-1:0]    out_byte,
  output logic                             out_is_sum,
  input  logic                             out_ready
);
  import stream_pkg::*;

  logic [BYTE_W-1:0] sum_q;     // Running sum of the current frame.
  logic              sum_pend;  // The frame ended and its sum is not yet loaded.
  logic [BYTE_W-1:0] ff_byte;
  logic              ff_last;
  logic              out_free;
  logic              ff_fire;
  logic              sum_load;

  assign ff_byte  = ff_data[BYTE_W-1:0];
  assign ff_last  = ff_data[PAYLOAD_W-1];
  assign out_free = !out_valid || out_ready;
  assign ff_ready = out_free && !sum_pend;  // The checksum goes out before the next frame.
  assign ff_fire  = ff_valid && ff_ready;
  assign sum_load = sum_pend && out_free;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      out_valid <= 1'b0;
      sum_pend  <= 1'b0;
      sum_q     <= '0;
    end else begin
      if (ff_fire) begin
        out_valid <= 1'b1;
        sum_q     <= sum_q + ff_byte;  // Wraps modulo 256.
        sum_pend  <= ff_last;
      end else if (sum_load) begin
        out_valid <= 1'b1;
        sum_q     <= '0;
        sum_pend  <= 1'b0;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge rd_clk) begin
    if (ff_fire) begin
      out_byte   <= ff_byte;
      out_is_sum <= 1'b0;
    end else if (sum_load) begin
      out_byte   <= sum_q;
      out_is_sum <= 1'b1;
    end
  end

  // A stalled output item stays on the port unchanged until it is taken.
  a_out_hold: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_byte) && $stable(out_is_sum)
  );

endmodule

// ==== design/gray_sync.sv ====
`timescale 1ns/1ps

module gray_sync #(
  parameter int PTR_W = 5
) (
  input  logic             dst_clk,
  input  logic             dst_rst_n,
  input  logic [PTR_W-1:0] gray_in,
  output logic [PTR_W-1:0] gray_out,
  output logic [PTR_W-1:0] bin_out
);

  logic [PTR_W-1:0] meta_q;  // First stage, may go metastable.
  logic [PTR_W-1:0] sync_q;

  // Only one bit of gray_in changes per source edge, so a late sample
  // gives either the old or the new pointer.
  always_ff @(posedge dst_clk or negedge dst_rst_n) begin
    if (!dst_rst_n) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= gray_in;
      sync_q <= meta_q;
    end
  end

  assign gray_out = sync_q;

  // Each binary bit is the XOR of all Gray bits at or above it.
  for (genvar i = 0; i < PTR_W; i++) begin : g_bin
    assign bin_out[i] = ^(sync_q >> i);
  end

endmodule

// ==== design/nibble_packer.sv ====
`timescale 1ns/1ps

module nibble_packer (
  input  logic                           wr_clk,
  input  logic                           wr_rst_n,
  input  logic                           in_valid,
  input  logic [stream_pkg::NIBBLE_W-1:0]  in_nibble,
  input  logic                           in_last,
  output logic                           in_ready,
  output logic                           pk_valid,
  output logic [stream_pkg::PAYLOAD_W-1:0] pk_data,
  input  logic                           pk_ready
);
  import stream_pkg::*;

  logic [NIBBLE_W-1:0] low_nib;    // First nibble of the pair being built.
  logic                half_full;  // High when low_nib holds a nibble.
  logic [BYTE_W-1:0]   byte_next;
  logic                in_fire;
  logic                byte_done;

  assign in_ready  = !pk_valid || pk_ready;  // Output register empty or being drained.
  assign in_fire   = in_valid && in_ready;
  assign byte_done = in_fire && (half_full || in_last);

  // A lone last nibble goes out with a zero high half.
  always_comb begin
    if (half_full) begin
      byte_next = {in_nibble, low_nib};
    end else begin
      byte_next = {{NIBBLE_W{1'b0}}, in_nibble};
    end
  end

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      half_full <= 1'b0;
      pk_valid  <= 1'b0;
    end else begin
      if (in_fire) begin
        half_full <= !half_full && !in_last;  // A frame end always closes the pair.
      end
      if (byte_done) begin
        pk_valid <= 1'b1;
      end else if (pk_ready) begin
        pk_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge wr_clk) begin
    if (in_fire && !half_full) begin
      low_nib <= in_nibble;
    end
    if (byte_done) begin
      pk_data <= {in_last, byte_next};
    end
  end

  // The FIFO may sample pk_data on any later edge, so a stalled byte must not move.
  a_pk_hold: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
    pk_valid && !pk_ready |=> pk_valid && $stable(pk_data)
  );

endmodule

// ==== design/stream_pkg.sv ====
package stream_pkg;

  // Width of one input nibble.
  localparam int NIBBLE_W = 4;

  // Width of a packed byte.
  localparam int BYTE_W = 8;

  // One FIFO entry. The byte is in the low bits and the last flag in the top bit.
  localparam int PAYLOAD_W = BYTE_W + 1;

  // Default FIFO depth. It must be a power of two.
  localparam int DEF_FIFO_DEPTH = 16;

  // Default almost-full threshold, counted in written entries.
  localparam int DEF_AFULL = 12;

  // Default almost-empty threshold, counted in entries still to read.
  localparam int DEF_AEMPTY = 2;

endpackage

// ==== design/stream_top.sv ====
`timescale 1ns/1ps

module stream_top #(
  parameter int FIFO_DEPTH   = stream_pkg::DEF_FIFO_DEPTH,
  parameter int AFULL_LEVEL  = stream_pkg::DEF_AFULL,
  parameter int AEMPTY_LEVEL = stream_pkg::DEF_AEMPTY
) (
  input  logic                            wr_clk,
  input  logic                            rd_clk,
  input  logic                            rd_rst_n,
  input  logic                            in_valid,
  output logic                            in_ready,
  input  logic [stream_pkg::NIBBLE_W-1:0] in_nibble,
  input  logic                            in_last,
  output logic                            out_valid,
  input  logic                            out_ready,
  output logic [stream_pkg::BYTE_W-1:0]   out_byte,
  output logic                            out_is_sum,
  output logic                            fifo_full,
  output logic                            fifo_afull,
  output logic                            fifo_empty,
  output logic                            fifo_aempty
);
  import stream_pkg::*;

  logic [1:0]           wr_rst_sync;
  logic                 wr_rst_n;
  logic                 pk_valid;
  logic                 pk_ready;
  logic [PAYLOAD_W-1:0] pk_data;
  logic                 ff_valid;
  logic                 ff_ready;
  logic [PAYLOAD_W-1:0] ff_data;

  // Reset enters the write domain at once and leaves it two wr_clk edges later.
  always_ff @(posedge wr_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      wr_rst_sync <= 2'b00;
    end else begin
      wr_rst_sync <= {wr_rst_sync[0], 1'b1};
    end
  end

  assign wr_rst_n = wr_rst_sync[1];

  nibble_packer u_packer (
    .wr_clk    (wr_clk),
    .wr_rst_n  (wr_rst_n),
    .in_valid  (in_valid),
    .in_nibble (in_nibble),
    .in_last   (in_last),
    .in_ready  (in_ready),
    .pk_valid  (pk_valid),
    .pk_data   (pk_data),
    .pk_ready  (pk_ready)
  );

  async_fifo #(
    .DATA_W       (PAYLOAD_W),
    .FIFO_DEPTH   (FIFO_DEPTH),
    .AFULL_LEVEL  (AFULL_LEVEL),
    .AEMPTY_LEVEL (AEMPTY_LEVEL)
  ) u_fifo (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_valid (pk_valid),
    .wr_data  (pk_data),
    .wr_ready (pk_ready),
    .full     (fifo_full),
    .afull    (fifo_afull),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_ready (ff_ready),
    .rd_valid (ff_valid),
    .rd_data  (ff_data),
    .empty    (fifo_empty),
    .aempty   (fifo_aempty)
  );

  frame_summer u_summer (
    .rd_clk     (rd_clk),
    .rd_rst_n   (rd_rst_n),
    .ff_valid   (ff_valid),
    .ff_data    (ff_data),
    .ff_ready   (ff_ready),
    .out_valid  (out_valid),
    .out_byte   (out_byte),
    .out_is_sum (out_is_sum),
    .out_ready  (out_ready)
  );

endmodule

// ==== testbench/stream_tests.txt ====
# N <nibble hex> <last> gives one input nibble, the first of a pair is the low half
# E <byte hex> <is_sum> gives one expected output byte, is_sum marks the checksum
N 1 0
N 2 0
N 3 0
N 4 1
E 21 0
E 43 0
E 64 1
N 5 0
N 6 0
N 7 1
E 65 0
E 07 0
E 6c 1
N f 0
N e 0
N d 0
N c 0
N b 0
N a 1
E ef 0
E cd 0
E ab 0
E 67 1
N 9 1
E 09 0
E 09 1

// ==== testbench/tb_stream_top.sv ====
`timescale 1ns/1ps

module tb_stream_top;
  import stream_pkg::*;

  localparam int REPEATS     = 3;    // The file is replayed so the FIFO can fill.
  localparam int STALL_START = 8;
  localparam int STALL_END   = 130;  // End of the long out_ready stall in rd_clk cycles.

  logic                wr_clk;
  logic                rd_clk;
  logic                rd_rst_n;
  logic                in_valid;
  logic                in_ready;
  logic [NIBBLE_W-1:0] in_nibble;
  logic                in_last;
  logic                out_valid;
  logic                out_ready = 1'b0;
  logic [BYTE_W-1:0]   out_byte;
  logic                out_is_sum;
  logic                fifo_full;
  logic                fifo_afull;
  logic                fifo_empty;
  logic                fifo_aempty;

  logic [NIBBLE_W:0] file_nibs[$];  // {last, nibble} per N line.
  logic [BYTE_W:0]   file_exps[$];  // {is_sum, byte} per E line.
  logic [BYTE_W:0]   exp_q[$];
  logic [BYTE_W:0]   exp_item;
  int                errors = 0;
  int                checked = 0;
  int                wr_cycles = 0;
  int                rd_cycles = 0;
  int                timeout_limit = 0;
  bit                saw_full = 1'b0;
  bit                saw_in_stall = 1'b0;
  bit                saw_aempty_low = 1'b0;

  stream_top u_dut (.*);

  initial begin
    wr_clk = 1'b0;
    forever #50 wr_clk = ~wr_clk;
  end

  initial begin
    rd_clk = 1'b0;
    #5;  // Keeps rd_clk edges away from wr_clk edges.
    forever #70 rd_clk = ~rd_clk;
  end

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic read_tests;
    int             fd;
    int             code;
    logic [7:0]     tag;
    logic [31:0]    val;
    logic [31:0]    flag;
    logic [8*96-1:0] rest;
    fd = $fopen("testbench/stream_tests.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open testbench/stream_tests.txt");
      return;
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", tag);
      if (code != 1) break;
      if (tag == "#") begin
        code = $fgets(rest, fd);
      end else if (tag == "N") begin
        code = $fscanf(fd, "%h %d", val, flag);
        file_nibs.push_back({flag[0], val[NIBBLE_W-1:0]});
      end else if (tag == "E") begin
        code = $fscanf(fd, "%h %d", val, flag);
        file_exps.push_back({flag[0], val[BYTE_W-1:0]});
      end else begin
        errors++;
        $display("The test file holds a line with an unknown tag");
      end
    end
    $fclose(fd);
  endtask

  initial begin
    int seed;
    int gap;
    seed      = $urandom(32'h9acbac16);
    rd_rst_n  = 1'b0;
    in_valid  = 1'b0;
    in_nibble = '0;
    in_last   = 1'b0;
    read_tests();
    for (int r = 0; r < REPEATS; r++) begin
      foreach (file_exps[i]) exp_q.push_back(file_exps[i]);
    end
    timeout_limit = 40 * (file_nibs.size() + file_exps.size()) * REPEATS + 200;
    repeat (4) @(posedge wr_clk);
    rd_rst_n <= 1'b1;
    repeat (3) @(posedge wr_clk);
    check_value(32'(out_valid), 32'd0, "out_valid after reset");
    check_value(32'(fifo_full), 32'd0, "fifo_full after reset");
    check_value(32'(fifo_afull), 32'd0, "fifo_afull after reset");
    check_value(32'(fifo_empty), 32'd1, "fifo_empty after reset");
    check_value(32'(fifo_aempty), 32'd1, "fifo_aempty after reset");
    check_value(32'(in_ready), 32'd1, "in_ready after reset");
    for (int r = 0; r < REPEATS; r++) begin
      foreach (file_nibs[i]) begin
        gap = $urandom % 3;
        if (gap != 0) begin
          in_valid <= 1'b0;
          repeat (gap) @(posedge wr_clk);
        end
        in_valid  <= 1'b1;
        in_nibble <= file_nibs[i][NIBBLE_W-1:0];
        in_last   <= file_nibs[i][NIBBLE_W];
        @(posedge wr_clk);
        while (!in_ready) @(posedge wr_clk);  // Hold the nibble until it is taken.
      end
    end
    in_valid <= 1'b0;
    while (exp_q.size() != 0) @(posedge rd_clk);
    repeat (20) @(posedge rd_clk);  // Room for any extra byte to show up.
    @(posedge wr_clk);
    if (!saw_full) begin
      errors++;
      $display("fifo_full never went high under back-pressure");
    end
    if (!saw_in_stall) begin
      errors++;
      $display("in_ready never dropped under back-pressure");
    end
    if (!saw_aempty_low) begin
      errors++;
      $display("fifo_aempty never went low while the FIFO held data");
    end
    $display("Checked %0d output bytes, %0d errors", checked, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  always @(posedge rd_clk) begin
    rd_cycles++;
    if (rd_rst_n && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Output byte %h at %0t ns arrived when no byte was expected", out_byte, $time);
      end else begin
        exp_item = exp_q.pop_front();
        check_value(32'(out_byte), 32'(exp_item[BYTE_W-1:0]), "output byte");
        check_value(32'(out_is_sum), 32'(exp_item[BYTE_W]), "checksum flag");
        checked++;
      end
    end
    // An empty FIFO holds nothing, which is below any almost-empty level.
    if (fifo_empty) begin
      check_value(32'(fifo_aempty), 32'd1, "fifo_aempty while fifo_empty");
    end
    if (!fifo_aempty) begin
      saw_aempty_low = 1'b1;
    end
    if (rd_cycles >= STALL_START && rd_cycles < STALL_END) begin
      out_ready <= 1'b0;
    end else begin
      out_ready <= ($urandom % 10) >= 4;  // Low about 40% of the time.
    end
  end

  always @(posedge wr_clk) begin
    wr_cycles++;
    // A full FIFO holds FIFO_DEPTH entries, which is above the almost-full level.
    if (fifo_full) begin
      saw_full = 1'b1;
      check_value(32'(fifo_afull), 32'd1, "fifo_afull while fifo_full");
    end
    if (!in_ready) begin
      saw_in_stall = 1'b1;
    end
    if (timeout_limit != 0 && wr_cycles >= timeout_limit) begin
      $display("Timeout after %0d wr_clk cycles, %0d expected bytes never arrived, %0d errors",
               wr_cycles, exp_q.size(), errors);
      $display("Test FAILED");
      $finish;
    end
  end

endmodule

// ==== vlog.f ====
design/stream_pkg.sv
design/nibble_packer.sv
design/dual_port_ram.sv
design/gray_sync.sv
design/async_fifo.sv
design/frame_summer.sv
design/stream_top.sv
testbench/tb_stream_top.sv
